/* project.f */
hw/rv_pkg.sv
hw/decoder.sv
hw/regbank.sv
hw/execute.sv
hw/exec_core.sv
bench/tb_clock.sv
bench/tb_exec_core.sv

/* run.sh */
#!/usr/bin/env bash
# Builds and runs the exec_core testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -Mdir obj_dir \
    --top-module tb_exec_core \
    -o sim_exec_core \
    -f project.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/sim_exec_core 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "Testbench passed"; then
    exit 0
fi

echo "pass message not found in simulation output"
exit 1

/* bench/tb_exec_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_exec_core;

    import rv_pkg::*;

    // instruction counts per test.
    localparam int n_reset     = 9;
    localparam int n_const     = 16;
    localparam int n_random    = 200;
    localparam int n_chains    = 4;
    localparam int chain_len   = 10;
    localparam int n_x0_pairs  = 4;
    localparam int n_illegal   = 8;
    localparam int total_instr = n_reset + 2 * n_const + n_random + n_chains * chain_len
                                 + 2 * n_x0_pairs + 2 * n_illegal;
    localparam int cycle_limit = 2 * total_instr + 100;

    // rv32i major opcodes.
    localparam logic [6:0] opc_reg = 7'b0110011;
    localparam logic [6:0] opc_imm = 7'b0010011;
    localparam logic [6:0] opc_lui = 7'b0110111;

    logic        clk;
    logic        reset_n;
    logic        instr_valid_i;
    logic [31:0] instr_i;
    wb_t         wb_o;

    // model of the architectural registers.
    logic [31:0] model_regs [32];
    // expected writebacks in issue order.
    wb_t         exp_q [$];
    logic [31:0] rng_state = 32'd48;
    int          errors    = 0;
    int          checks    = 0;
    int          cycles    = 0;

    tb_clock i_clock (
        .clk_o (clk)
    );

    exec_core i_exec_core (
        .clk           (clk),
        .reset_n       (reset_n),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .wb_o          (wb_o)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] rand32();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                          input logic [4:0] rs2, input logic [4:0] rs1,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, opc_reg};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [2:0] f3,
                                          input logic [4:0] rs1, input logic [4:0] rd);
        return {imm, rs1, f3, rd, opc_imm};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, opc_lui};
    endfunction

    // one of the twelve supported r-type and i-type operations.
    function automatic logic [31:0] build_alu(input logic [3:0] sel, input logic [4:0] rd,
                                              input logic [4:0] rs1, input logic [4:0] rs2,
                                              input logic [11:0] imm);
        case (sel)
            4'd0:    return enc_r(7'h00, 3'b000, rs2, rs1, rd);
            4'd1:    return enc_r(7'h20, 3'b000, rs2, rs1, rd);
            4'd2:    return enc_r(7'h00, 3'b111, rs2, rs1, rd);
            4'd3:    return enc_r(7'h00, 3'b110, rs2, rs1, rd);
            4'd4:    return enc_r(7'h00, 3'b100, rs2, rs1, rd);
            4'd5:    return enc_r(7'h00, 3'b010, rs2, rs1, rd);
            4'd6:    return enc_r(7'h00, 3'b001, rs2, rs1, rd);
            4'd7:    return enc_r(7'h00, 3'b101, rs2, rs1, rd);
            4'd8:    return enc_i(imm, 3'b000, rs1, rd);
            4'd9:    return enc_i(imm, 3'b111, rs1, rd);
            4'd10:   return enc_i(imm, 3'b110, rs1, rd);
            default: return enc_i(imm, 3'b100, rs1, rd);
        endcase
    endfunction

    // encodings outside the supported subset.
    function automatic logic [31:0] illegal_instr(input logic [2:0] idx, input logic [4:0] rd,
                                                  input logic [4:0] rs1, input logic [4:0] rs2);
        case (idx)
            3'd0:    return {12'h004, rs1, 3'b010, rd, 7'b0000011};
            3'd1:    return enc_r(7'h00, 3'b011, rs2, rs1, rd);
            3'd2:    return enc_r(7'h01, 3'b000, rs2, rs1, rd);
            3'd3:    return enc_r(7'h20, 3'b101, rs2, rs1, rd);
            3'd4:    return enc_i(12'h005, 3'b001, rs1, rd);
            3'd5:    return enc_i(12'h123, 3'b010, rs1, rd);
            // addi with sub-style upper bits.
            3'd6:    return enc_i(12'h405, 3'b000, rs1, rd);
            default: return {20'h12345, rd, 7'b1101111};
        endcase
    endfunction

    // reference model that returns the expected writeback and updates model_regs.
    function automatic wb_t predict_wb(input logic [31:0] instr);
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [4:0]  rd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic        legal;
        logic [31:0] res;
        wb_t         wb;
        opc   = instr[6:0];
        f3    = instr[14:12];
        f7    = instr[31:25];
        rd    = instr[11:7];
        a     = model_regs[instr[19:15]];
        b     = model_regs[instr[24:20]];
        imm   = {{20{instr[31]}}, instr[31:20]};
        legal = 1'b1;
        res   = 32'h0;
        if (opc == opc_reg && f7 == 7'h00) begin
            case (f3)
                3'b000:  res = a + b;
                3'b001:  res = a << b[4:0];
                3'b010:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                3'b100:  res = a ^ b;
                3'b101:  res = a >> b[4:0];
                3'b110:  res = a | b;
                3'b111:  res = a & b;
                default: legal = 1'b0;
            endcase
        end else if (opc == opc_reg && f7 == 7'h20 && f3 == 3'b000) begin
            res = a - b;
        end else if (opc == opc_imm && f7 != 7'h20) begin
            case (f3)
                3'b000:  res = a + imm;
                3'b100:  res = a ^ imm;
                3'b110:  res = a | imm;
                3'b111:  res = a & imm;
                default: legal = 1'b0;
            endcase
        end else if (opc == opc_lui) begin
            res = {instr[31:12], 12'h000};
        end else begin
            legal = 1'b0;
        end
        wb.valid   = 1'b1;
        wb.illegal = !legal;
        wb.rd      = rd;
        wb.data    = legal ? res : 32'h0;
        // x0 stays zero.
        if (legal && rd != 5'd0) begin
            model_regs[rd] = res;
        end
        return wb;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, want);
        end
    endtask

    task automatic send_instr(input logic [31:0] instr);
        @(negedge clk);
        instr_valid_i = 1'b1;
        instr_i       = instr;
        exp_q.push_back(predict_wb(instr));
    endtask

    // stop issuing and wait for all writebacks.
    task automatic drain_pipeline();
        @(negedge clk);
        instr_valid_i = 1'b0;
        instr_i       = 32'h0;
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
    endtask

    // compare process samples mid-cycle after the falling edge.
    initial begin : compare_wb
        wb_t want;
        forever begin
            @(negedge clk);
            #1;
            if (reset_n === 1'b1 && wb_o.valid === 1'b1) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("writeback at cycle %0d with no instruction outstanding", cycles);
                end else begin
                    want = exp_q.pop_front();
                    compare_value("wb_o.illegal", 32'(wb_o.illegal), 32'(want.illegal));
                    compare_value("wb_o.rd", 32'(wb_o.rd), 32'(want.rd));
                    compare_value("wb_o.data", wb_o.data, want.data);
                end
            end
        end
    end

    initial begin : watchdog
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, writebacks stopped arriving", cycle_limit);
        $display("Testbench failed");
        $finish;
    end

    initial begin : stimulus
        int          base;
        logic [31:0] c;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  prev_rd;
        logic [3:0]  sel;
        reset_n       = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = 32'h0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = 32'h0;
        end
        repeat (4) @(negedge clk);
        reset_n = 1'b1;

        // test 1 checks that registers read zero after reset.
        base = errors;
        send_instr(enc_r(7'h00, 3'b000, 5'd0, 5'd0, 5'd1));
        for (int i = 0; i < n_reset - 1; i++) begin
            rd  = 5'(rand32());
            rs1 = 5'(rand32());
            send_instr(enc_r(7'h00, 3'b000, 5'd0, rs1, rd));
        end
        drain_pipeline();
        $display("test 1 reset values: %0d instructions, %0d errors", n_reset, errors - base);

        // test 2 builds constants with lui and addi.
        base = errors;
        for (int i = 0; i < n_const; i++) begin
            rd = 5'(rand32() % 31 + 1);
            c  = rand32();
            // keep the addi immediate legal.
            if (c[11:5] == 7'h20) begin
                c[5] = 1'b1;
            end
            // upper part rounds up when the low part is negative.
            send_instr(enc_u(20'((c + 32'h800) >> 12), rd));
            send_instr(enc_i(c[11:0], 3'b000, rd, rd));
            compare_value("model constant", model_regs[rd], c);
        end
        drain_pipeline();
        $display("test 2 constants: %0d instructions, %0d errors", 2 * n_const, errors - base);

        // test 3 runs random alu operations.
        base = errors;
        for (int i = 0; i < n_random; i++) begin
            sel = 4'(rand32() % 12);
            rd  = 5'(rand32());
            rs1 = 5'(rand32());
            rs2 = 5'(rand32());
            send_instr(build_alu(sel, rd, rs1, rs2, 12'(rand32())));
        end
        drain_pipeline();
        $display("test 3 random ops: %0d instructions, %0d errors", n_random, errors - base);

        // test 4 runs dependent chains with no gaps.
        base = errors;
        for (int k = 0; k < n_chains; k++) begin
            prev_rd = 5'(rand32() % 31 + 1);
            for (int i = 0; i < chain_len; i++) begin
                sel = 4'(rand32() % 12);
                rd  = 5'(rand32() % 31 + 1);
                rs2 = 5'(rand32());
                send_instr(build_alu(sel, rd, prev_rd, rs2, 12'(rand32())));
                prev_rd = rd;
            end
        end
        drain_pipeline();
        $display("test 4 dependent chains: %0d instructions, %0d errors",
                 n_chains * chain_len, errors - base);

        // test 5 checks that x0 writes are reported but not kept.
        base = errors;
        for (int i = 0; i < n_x0_pairs; i++) begin
            rs1   = 5'(rand32() % 31 + 1);
            rd    = 5'(rand32() % 31 + 1);
            c     = rand32();
            c[10] = 1'b0;
            send_instr(enc_i(c[11:0], 3'b110, rs1, 5'd0));
            send_instr(enc_r(7'h00, 3'b000, 5'd0, 5'd0, rd));
        end
        drain_pipeline();
        $display("test 5 x0 writes: %0d instructions, %0d errors",
                 2 * n_x0_pairs, errors - base);

        // test 6 sends illegal encodings and reads back their rd.
        base = errors;
        for (int i = 0; i < n_illegal; i++) begin
            rd  = 5'(rand32() % 31 + 1);
            rs1 = 5'(rand32());
            rs2 = 5'(rand32());
            send_instr(illegal_instr(3'(i), rd, rs1, rs2));
            send_instr(enc_r(7'h00, 3'b000, 5'd0, rd, rd));
        end
        drain_pipeline();
        $display("test 6 illegal encodings: %0d instructions, %0d errors",
                 2 * n_illegal, errors - base);

        // catch late writebacks.
        repeat (3) @(negedge clk);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* bench/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk_o
);

    // 20 ns period.
    localparam time half_period = 10ns;

    initial begin
        clk_o = 1'b0;
        forever begin
            #half_period;
            clk_o = ~clk_o;
        end
    end

endmodule

`default_nettype wire

/* hw/exec_core.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_core (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    instr_valid_i,
    input  logic [rv_pkg::xlen-1:0] instr_i,
    output rv_pkg::wb_t             wb_o
);

    import rv_pkg::*;

    // decoder to execute.
    dec_op_t dec_op;

    // execute to bank.
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic [xlen-1:0]       rdata1;
    logic [xlen-1:0]       rdata2;
    logic                  wr_en;
    logic [reg_addr_w-1:0] wr_addr;
    logic [xlen-1:0]       wr_data;

    decoder i_decoder (
        .clk           (clk),
        .reset_n       (reset_n),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .dec_op_o      (dec_op)
    );

    regbank i_regbank (
        .clk       (clk),
        .reset_n   (reset_n),
        .rs1_i     (rs1),
        .rs2_i     (rs2),
        .wr_en_i   (wr_en),
        .wr_addr_i (wr_addr),
        .wr_data_i (wr_data),
        .rdata1_o  (rdata1),
        .rdata2_o  (rdata2)
    );

    execute i_execute (
        .clk       (clk),
        .reset_n   (reset_n),
        .dec_op_i  (dec_op),
        .rs1_o     (rs1),
        .rs2_o     (rs2),
        .rdata1_i  (rdata1),
        .rdata2_i  (rdata2),
        .wr_en_o   (wr_en),
        .wr_addr_o (wr_addr),
        .wr_data_o (wr_data),
        .wb_o      (wb_o)
    );

endmodule

`default_nettype wire

/* hw/execute.sv */
`timescale 1ns/1ps
`default_nettype none

module execute (
    input  logic                        clk,
    input  logic                        reset_n,
    input  rv_pkg::dec_op_t             dec_op_i,
    output logic [rv_pkg::reg_addr_w-1:0] rs1_o,
    output logic [rv_pkg::reg_addr_w-1:0] rs2_o,
    input  logic [rv_pkg::xlen-1:0]     rdata1_i,
    input  logic [rv_pkg::xlen-1:0]     rdata2_i,
    output logic                        wr_en_o,
    output logic [rv_pkg::reg_addr_w-1:0] wr_addr_o,
    output logic [rv_pkg::xlen-1:0]     wr_data_o,
    output rv_pkg::wb_t                 wb_o
);

    import rv_pkg::*;

    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;
    logic [4:0]      shamt;
    logic [xlen-1:0] alu_result;
    wb_t             wb_q;

    // operand fetch from the bank.
    assign rs1_o = dec_op_i.rs1;
    assign rs2_o = dec_op_i.rs2;

    // operand b is imm or rs2.
    assign op_a  = rdata1_i;
    assign op_b  = dec_op_i.use_imm ? dec_op_i.imm : rdata2_i;
    // shifts take the low 5 bits only.
    assign shamt = op_b[4:0];

    always_comb begin
        case (dec_op_i.alu_op)
            alu_add:    alu_result = op_a + op_b;
            alu_sub:    alu_result = op_a - op_b;
            alu_and:    alu_result = op_a & op_b;
            alu_or:     alu_result = op_a | op_b;
            alu_xor:    alu_result = op_a ^ op_b;
            // signed compare.
            alu_slt:    alu_result = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            alu_sll:    alu_result = op_a << shamt;
            alu_srl:    alu_result = op_a >> shamt;
            alu_pass_b: alu_result = op_b;
            default:    alu_result = '0;
        endcase
    end

    // bank write lands with the wb register.
    // x0 writes are dropped here.
    assign wr_en_o   = dec_op_i.valid && !dec_op_i.illegal && (dec_op_i.rd != '0);
    assign wr_addr_o = dec_op_i.rd;
    assign wr_data_o = alu_result;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wb_q <= '0;
        end else begin
            wb_q.valid   <= dec_op_i.valid;
            wb_q.illegal <= dec_op_i.valid && dec_op_i.illegal;
            wb_q.rd      <= dec_op_i.rd;
            // illegal ops report zero data.
            wb_q.data    <= dec_op_i.illegal ? '0 : alu_result;
        end
    end

    assign wb_o = wb_q;

    // no bank write for an illegal op.
    a_wr_legal: assert property (
        @(posedge clk) disable iff (!reset_n)
        wr_en_o |-> !dec_op_i.illegal
    );

endmodule

`default_nettype wire

/* hw/regbank.sv */
`timescale 1ns/1ps
`default_nettype none

module regbank (
    input  logic                        clk,
    input  logic                        reset_n,
    input  logic [rv_pkg::reg_addr_w-1:0] rs1_i,
    input  logic [rv_pkg::reg_addr_w-1:0] rs2_i,
    input  logic                        wr_en_i,
    input  logic [rv_pkg::reg_addr_w-1:0] wr_addr_i,
    input  logic [rv_pkg::xlen-1:0]     wr_data_i,
    output logic [rv_pkg::xlen-1:0]     rdata1_o,
    output logic [rv_pkg::xlen-1:0]     rdata2_o
);

    import rv_pkg::*;

    // read view of all registers.
    logic [xlen-1:0] regs [reg_count];

    for (genvar i = 0; i < reg_count; i++) begin : g_reg
        if (i == 0) begin : g_zero
            // x0 is hardwired.
            assign regs[i] = '0;
        end else begin : g_rw
            logic [xlen-1:0] q;

            always_ff @(posedge clk or negedge reset_n) begin
                if (!reset_n) begin
                    q <= '0;
                end else if (wr_en_i && wr_addr_i == reg_addr_w'(i)) begin
                    q <= wr_data_i;
                end
            end

            assign regs[i] = q;
        end
    end

    // direct index reads, no bypass.
    assign rdata1_o = regs[rs1_i];
    assign rdata2_o = regs[rs2_i];

    // write address must be known when writing.
    a_wr_addr_known: assert property (
        @(posedge clk) disable iff (!reset_n)
        wr_en_i |-> !$isunknown(wr_addr_i)
    );

endmodule

`default_nettype wire

/* hw/decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module decoder (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  instr_valid_i,
    input  logic [rv_pkg::xlen-1:0] instr_i,
    output rv_pkg::dec_op_t       dec_op_o
);

    import rv_pkg::*;

    // instruction fields.
    opcode_e    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    dec_op_t dec_next;
    dec_op_t dec_q;

    assign opcode = opcode_e'(instr_i[6:0]);
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    // combinational decode of the incoming word.
    always_comb begin
        dec_next         = '0;
        dec_next.valid   = 1'b1;
        dec_next.rd      = instr_i[11:7];
        dec_next.rs1     = instr_i[19:15];
        dec_next.rs2     = instr_i[24:20];
        dec_next.alu_op  = alu_add;
        case (opcode)
            op_reg: begin
                // funct7 must be base, except for sub.
                case ({funct7, funct3})
                    {f7_base, f3_add}: dec_next.alu_op = alu_add;
                    {f7_alt, f3_add}:  dec_next.alu_op = alu_sub;
                    {f7_base, f3_and}: dec_next.alu_op = alu_and;
                    {f7_base, f3_or}:  dec_next.alu_op = alu_or;
                    {f7_base, f3_xor}: dec_next.alu_op = alu_xor;
                    {f7_base, f3_slt}: dec_next.alu_op = alu_slt;
                    {f7_base, f3_sll}: dec_next.alu_op = alu_sll;
                    {f7_base, f3_srl}: dec_next.alu_op = alu_srl;
                    default:           dec_next.illegal = 1'b1;
                endcase
            end
            op_imm: begin
                // i-type immediate, sign-extended.
                dec_next.use_imm = 1'b1;
                dec_next.imm     = {{(xlen-12){instr_i[31]}}, instr_i[31:20]};
                case (funct3)
                    f3_add:  dec_next.alu_op = alu_add;
                    f3_and:  dec_next.alu_op = alu_and;
                    f3_or:   dec_next.alu_op = alu_or;
                    f3_xor:  dec_next.alu_op = alu_xor;
                    default: dec_next.illegal = 1'b1;
                endcase
                // sub-style upper bits are rejected on i-type.
                if (funct7 == f7_alt) begin
                    dec_next.illegal = 1'b1;
                end
            end
            op_lui: begin
                // u-type immediate, low 12 bits clear.
                dec_next.use_imm = 1'b1;
                dec_next.alu_op  = alu_pass_b;
                dec_next.imm     = {instr_i[31:12], 12'b0};
            end
            default: begin
                dec_next.illegal = 1'b1;
            end
        endcase
    end

    // one register stage between decode and execute.
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            dec_q <= '0;
        end else if (instr_valid_i) begin
            dec_q <= dec_next;
        end else begin
            // bubble.
            dec_q.valid   <= 1'b0;
            dec_q.illegal <= 1'b0;
        end
    end

    assign dec_op_o = dec_q;

    // an illegal flag never travels on a bubble.
    a_illegal_valid: assert property (
        @(posedge clk) disable iff (!reset_n)
        dec_op_o.illegal |-> dec_op_o.valid
    );

endmodule

`default_nettype wire

/* hw/rv_pkg.sv */
`default_nettype none

package rv_pkg;

    // data path width.
    localparam int xlen = 32;
    // architectural register count.
    localparam int reg_count = 32;
    // register index width.
    localparam int reg_addr_w = 5;

    // funct3 codes of the supported subset.
    localparam logic [2:0] f3_add = 3'b000;
    localparam logic [2:0] f3_sll = 3'b001;
    localparam logic [2:0] f3_slt = 3'b010;
    localparam logic [2:0] f3_xor = 3'b100;
    localparam logic [2:0] f3_srl = 3'b101;
    localparam logic [2:0] f3_or  = 3'b110;
    localparam logic [2:0] f3_and = 3'b111;

    // funct7 codes.
    // alt selects sub in r-type.
    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_alt  = 7'b0100000;

    // major opcodes.
    typedef enum logic [6:0] {
        op_reg = 7'b0110011,
        op_imm = 7'b0010011,
        op_lui = 7'b0110111
    } opcode_e;

    // alu functions.
    // pass_b forwards operand b, used by lui.
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sll,
        alu_srl,
        alu_pass_b
    } alu_op_e;

    // one decoded operation.
    typedef struct packed {
        logic                  valid;
        logic                  illegal;
        alu_op_e               alu_op;
        logic [reg_addr_w-1:0] rs1;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rd;
        logic                  use_imm;
        logic [xlen-1:0]       imm;
    } dec_op_t;

    // one writeback as seen at the top.
    typedef struct packed {
        logic                  valid;
        logic                  illegal;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       data;
    } wb_t;

endpackage

`default_nettype wire
